// ==== Makefile ====
TOP := ccu_read_path_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f ccu_read_path.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f ccu_read_path.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== ccu_read_path.f ====
hdl/ace_pkg.sv
hdl/ccu_pkg.sv
hdl/stream_fifo.sv
hdl/ccu_req_classifier.sv
hdl/ccu_completion_tracker.sv
hdl/ccu_read_path.sv
tests/tb_clock.sv
tests/ccu_read_path_props.sv
tests/ccu_read_path_tb.sv

// ==== hdl/ace_pkg.sv ====
package ace_pkg;

  ////////////////////////////////////////////////////////////
  // Channel widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned ID_W   = 4;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Shareability domain codes
  localparam logic [1:0] DOMAIN_NONSHARE = 2'd0;
  localparam logic [1:0] DOMAIN_INNER    = 2'd1;
  localparam logic [1:0] DOMAIN_OUTER    = 2'd2;
  localparam logic [1:0] DOMAIN_SYSTEM   = 2'd3;

  ////////////////////////////////////////////////////////////
  // Read channels
  ////////////////////////////////////////////////////////////

  // AR beat, one per read
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [1:0]        domain;
  } ar_req_t;

  // Single-beat R response
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
  } r_resp_t;

endpackage

// ==== hdl/ccu_completion_tracker.sv ====
`timescale 1ns/1ps

module ccu_completion_tracker (
  input  logic               clk_i,
  input  logic               reset_i,
  input  ace_pkg::r_resp_t   mem_r_i,
  input  logic               mem_r_valid_i,
  output logic               mem_r_ready_o,
  output ace_pkg::r_resp_t   r_o,
  output logic               r_valid_o,
  input  logic               r_ready_i,
  input  ccu_pkg::read_tag_t tag_i,
  input  logic               tag_valid_i,
  output logic               tag_ready_o,
  input  logic               rack_i,
  output logic               cm_req_o,
  output ccu_pkg::cm_addr_t  cm_addr_o
);

  import ccu_pkg::*;

  logic     resp_allowed;
  logic     r_xfer;
  logic     ack_push;
  logic     ack_ready;
  cm_addr_t ack_head;

  ////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////

  // Needs its tag, and room for the line index if snooping
  assign resp_allowed = tag_valid_i && (!tag_i.snoop || ack_ready);

  assign r_o           = mem_r_i;
  assign r_valid_o     = mem_r_valid_i && resp_allowed;
  assign mem_r_ready_o = r_ready_i && resp_allowed;

  assign r_xfer = mem_r_valid_i && r_ready_i && resp_allowed;

  // Tag retires with its response
  assign tag_ready_o = r_xfer;
  assign ack_push    = r_xfer && tag_i.snoop;

  ////////////////////////////////////////////////////////////
  // Ack queue
  ////////////////////////////////////////////////////////////

  stream_fifo #(
    .DEPTH     (ACK_DEPTH),
    .payload_t (cm_addr_t)
  ) u_ack_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_data_i   (tag_i.cm_addr),
    .in_valid_i  (ack_push),
    .in_ready_o  (ack_ready),
    .out_data_o  (ack_head),
    .out_valid_o (),
    .out_ready_i (rack_i)
  );

  // Each acknowledge retires the oldest snooping line
  assign cm_req_o  = rack_i;
  assign cm_addr_o = ack_head;

endmodule

// ==== hdl/ccu_pkg.sv ====
package ccu_pkg;

  ////////////////////////////////////////////////////////////
  // Line geometry
  ////////////////////////////////////////////////////////////

  // 64 byte cache lines
  localparam int unsigned LINE_OFFSET = 6;
  localparam int unsigned CM_ADDR_W   = 10;

  // Outstanding reads and unacknowledged snooping reads
  localparam int unsigned TAG_DEPTH = 8;
  localparam int unsigned ACK_DEPTH = 2;

  ////////////////////////////////////////////////////////////
  // Tracking types
  ////////////////////////////////////////////////////////////

  typedef logic [CM_ADDR_W-1:0] cm_addr_t;

  // Queued per read until its response returns
  typedef struct packed {
    logic     snoop;
    cm_addr_t cm_addr;
  } read_tag_t;

endpackage

// ==== hdl/ccu_read_path.sv ====
`timescale 1ns/1ps

module ccu_read_path (
  input  logic              clk_i,
  input  logic              reset_i,
  input  ace_pkg::ar_req_t  ar_i,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  output ace_pkg::ar_req_t  mem_ar_o,
  output logic              mem_ar_valid_o,
  input  logic              mem_ar_ready_i,
  input  ace_pkg::r_resp_t  mem_r_i,
  input  logic              mem_r_valid_i,
  output logic              mem_r_ready_o,
  output ace_pkg::r_resp_t  r_o,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  input  logic              rack_i,
  output logic              cm_req_o,
  output ccu_pkg::cm_addr_t cm_addr_o
);

  import ccu_pkg::*;

  read_tag_t push_tag;
  logic      push_tag_valid;
  logic      push_tag_ready;
  read_tag_t head_tag;
  logic      head_tag_valid;
  logic      head_tag_ready;

  ccu_req_classifier u_classifier (
    .ar_i           (ar_i),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_o     (ar_ready_o),
    .mem_ar_o       (mem_ar_o),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .tag_o          (push_tag),
    .tag_valid_o    (push_tag_valid),
    .tag_ready_i    (push_tag_ready)
  );

  // One tag per outstanding read, in memory order
  stream_fifo #(
    .DEPTH     (TAG_DEPTH),
    .payload_t (read_tag_t)
  ) u_tag_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_data_i   (push_tag),
    .in_valid_i  (push_tag_valid),
    .in_ready_o  (push_tag_ready),
    .out_data_o  (head_tag),
    .out_valid_o (head_tag_valid),
    .out_ready_i (head_tag_ready)
  );

  ccu_completion_tracker u_tracker (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mem_r_i       (mem_r_i),
    .mem_r_valid_i (mem_r_valid_i),
    .mem_r_ready_o (mem_r_ready_o),
    .r_o           (r_o),
    .r_valid_o     (r_valid_o),
    .r_ready_i     (r_ready_i),
    .tag_i         (head_tag),
    .tag_valid_i   (head_tag_valid),
    .tag_ready_o   (head_tag_ready),
    .rack_i        (rack_i),
    .cm_req_o      (cm_req_o),
    .cm_addr_o     (cm_addr_o)
  );

endmodule

// ==== hdl/ccu_req_classifier.sv ====
`timescale 1ns/1ps

module ccu_req_classifier (
  input  ace_pkg::ar_req_t   ar_i,
  input  logic               ar_valid_i,
  output logic               ar_ready_o,
  output ace_pkg::ar_req_t   mem_ar_o,
  output logic               mem_ar_valid_o,
  input  logic               mem_ar_ready_i,
  output ccu_pkg::read_tag_t tag_o,
  output logic               tag_valid_o,
  input  logic               tag_ready_i
);

  import ace_pkg::*;
  import ccu_pkg::*;

  logic snooping;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  // Only inner and outer shareable reads snoop
  always_comb begin
    case (ar_i.domain)
      DOMAIN_INNER: snooping = 1'b1;
      DOMAIN_OUTER: snooping = 1'b1;
      default:      snooping = 1'b0;
    endcase
  end

  assign tag_o.snoop   = snooping;
  assign tag_o.cm_addr = ar_i.addr[LINE_OFFSET +: CM_ADDR_W];

  ////////////////////////////////////////////////////////////
  // Fork
  ////////////////////////////////////////////////////////////

  // Request passes through unchanged
  assign mem_ar_o = ar_i;

  // Each side sees valid only when the other can take it too
  assign mem_ar_valid_o = ar_valid_i && tag_ready_i;
  assign tag_valid_o    = ar_valid_i && mem_ar_ready_i;
  assign ar_ready_o     = mem_ar_ready_i && tag_ready_i;

endmodule

// ==== hdl/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
  parameter int unsigned DEPTH     = 4,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  payload_t in_data_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output payload_t out_data_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  payload_t mem_q [DEPTH];
  ptr_t     rd_ptr_q;
  ptr_t     wr_ptr_q;
  cnt_t     count_q;
  logic     push;
  logic     pop;

  // Wrap at DEPTH, which need not be a power of two
  function automatic ptr_t next_ptr(ptr_t ptr);
    if (ptr == ptr_t'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign in_ready_o  = (count_q != cnt_t'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== tests/ccu_read_path_golden.txt ====
// Columns: id addr domain mem_data exp_snoop exp_line_index (all hex)
// Domain 0 non-shareable, 1 inner, 2 outer, 3 system
1 00001040 1 a5a50001 1 041
2 00002000 0 11110002 0 080
3 0000c3c4 2 22220003 1 30f
4 80000100 3 33330004 0 004
5 0001fffc 1 44440005 1 3ff
6 00000000 2 55550006 1 000
7 12345678 0 66660007 0 159
8 0000ff00 1 77770008 1 3fc
9 00000840 3 88880009 0 021
a 00002480 2 9999000a 1 092
b deadbeef 1 aaaa000b 1 2fb
c 00000fc0 0 bbbb000c 0 03f
d 00004004 2 cccc000d 1 100
e 00007fc0 3 dddd000e 0 1ff
f 0000a000 1 eeee000f 1 280
0 00000100 2 ffff0010 1 004

// ==== tests/ccu_read_path_props.sv ====
`timescale 1ns/1ps

module ccu_read_path_props (
  input logic              clk_i,
  input logic              reset_i,
  input ace_pkg::r_resp_t  r_i,
  input logic              r_valid_i,
  input logic              r_ready_i,
  input logic              rack_i,
  input logic              cm_req_i,
  input ccu_pkg::cm_addr_t cm_addr_i,
  input logic              ack_push_i,
  input ccu_pkg::cm_addr_t ack_line_i
);

  import ccu_pkg::*;

  logic [1:0] ack_level_q;
  cm_addr_t   head_line_q;
  cm_addr_t   next_line_q;

  // Ack queue occupancy
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_level_q <= '0;
    end else begin
      ack_level_q <= ack_level_q + 2'(ack_push_i) - 2'(rack_i);
    end
  end

  // Shadow copy of the two queued line indices, oldest first
  always_ff @(posedge clk_i) begin
    case ({ack_push_i, rack_i})
      2'b10: begin
        if (ack_level_q == 2'd0) begin
          head_line_q <= ack_line_i;
        end else begin
          next_line_q <= ack_line_i;
        end
      end
      2'b01: begin
        head_line_q <= next_line_q;
      end
      2'b11: begin
        if (ack_level_q == 2'd1) begin
          head_line_q <= ack_line_i;
        end else begin
          head_line_q <= next_line_q;
          next_line_q <= ack_line_i;
        end
      end
      default: ;
    endcase
  end

  a_rack_has_entry: assert property (
    @(posedge clk_i) disable iff (reset_i) rack_i |-> (ack_level_q != '0)
  ) else $error("Read acknowledge arrived with the ack queue empty");

  a_r_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
      (r_valid_i && !r_ready_i) |=> (r_valid_i && $stable(r_i))
  ) else $error("Response valid dropped or data changed before ready");

  a_cm_follows_rack: assert property (
    @(posedge clk_i) disable iff (reset_i)
      rack_i |-> (cm_req_i && (cm_addr_i == head_line_q))
  ) else $error("Acknowledge did not retire the oldest queued snooping line");

endmodule

// ==== tests/ccu_read_path_tb.sv ====
`timescale 1ns/1ps

module ccu_read_path_tb;

  import ace_pkg::*;
  import ccu_pkg::*;

  localparam int NUM_READS       = 16;
  localparam int WORDS           = 6;
  localparam int RESET_CYCLES    = 16;
  localparam int CYCLES_PER_READ = 200;

  logic     clk;
  logic     reset;
  ar_req_t  ar_i           = '0;
  logic     ar_valid_i     = 1'b0;
  logic     mem_ar_ready_i = 1'b0;
  r_resp_t  mem_r_i        = '0;
  logic     mem_r_valid_i  = 1'b0;
  logic     r_ready_i      = 1'b0;
  logic     rack_i         = 1'b0;
  logic     ar_ready_o;
  logic     mem_ar_valid_o;
  logic     mem_r_ready_o;
  logic     r_valid_o;
  logic     cm_req_o;
  ar_req_t  mem_ar_o;
  r_resp_t  r_o;
  cm_addr_t cm_addr_o;

  logic [31:0] golden_words [NUM_READS*WORDS];
  logic [15:0] lfsr_state = 16'd12;
  cm_addr_t    exp_cm_q [$];
  logic        traffic_on = 1'b0;
  logic        mem_r_hold = 1'b1;
  logic        rack_hold  = 1'b1;
  int          ar_sent        = 0;
  int          mem_acc_cnt    = 0;
  int          mem_resp_idx   = 0;
  int          resp_cnt       = 0;
  int          snoop_resp_cnt = 0;
  int          ack_pending    = 0;
  int          cm_cnt         = 0;
  int          num_snoop      = 0;

  tb_clock #(.RESET_CYCLES(RESET_CYCLES)) u_clock (.clk_o(clk), .reset_o(reset));

  ccu_read_path dut (.clk_i(clk), .reset_i(reset), .*);

  bind ccu_completion_tracker ccu_read_path_props u_props (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .r_i        (r_o),
    .r_valid_i  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .rack_i     (rack_i),
    .cm_req_i   (cm_req_o),
    .cm_addr_i  (cm_addr_o),
    .ack_push_i (ack_push),
    .ack_line_i (tag_i.cm_addr)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Taps 16 14 13 11
  function automatic logic random_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic ar_req_t golden_req(int k);
    ar_req_t req;
    req.id     = golden_words[k*WORDS][ID_W-1:0];
    req.addr   = golden_words[k*WORDS+1];
    req.domain = golden_words[k*WORDS+2][1:0];
    return req;
  endfunction

  function automatic r_resp_t golden_resp(int k);
    r_resp_t resp;
    resp.id   = golden_words[k*WORDS][ID_W-1:0];
    resp.data = golden_words[k*WORDS+3];
    return resp;
  endfunction

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_req(string name, ar_req_t exp, ar_req_t act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_resp(string name, r_resp_t exp, r_resp_t act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch in %s: expected id=%h data=%h, actual id=%h data=%h",
                          name, exp.id, exp.data, act.id, act.data));
    end
  endtask

  task automatic check_cm_addr(string name, cm_addr_t exp, cm_addr_t act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Requester and memory models
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic ar_busy;
    logic mem_r_busy;
    if (reset || !traffic_on) begin
      ar_valid_i     <= 1'b0;
      mem_ar_ready_i <= 1'b1;
      mem_r_valid_i  <= 1'b0;
      r_ready_i      <= 1'b0;
      rack_i         <= 1'b0;
    end else begin
      ar_busy = ar_valid_i && !ar_ready_o;
      if (ar_valid_i && ar_ready_o) begin
        ar_sent++;
      end
      if (!ar_busy) begin
        ar_valid_i <= (ar_sent < NUM_READS);
        ar_i       <= golden_req(ar_sent % NUM_READS);
      end
      if (mem_ar_valid_o && mem_ar_ready_i) begin
        check_req($sformatf("read %0d request", mem_acc_cnt), golden_req(mem_acc_cnt),
                  mem_ar_o);
        mem_acc_cnt++;
      end
      mem_ar_ready_i <= random_bit();
      // Memory answers in order, holding valid until taken
      mem_r_busy = mem_r_valid_i && !mem_r_ready_o;
      if (!mem_r_busy) begin
        mem_r_valid_i <= 1'b0;
        if (!mem_r_hold && mem_resp_idx < mem_acc_cnt && random_bit()) begin
          mem_r_i       <= golden_resp(mem_resp_idx);
          mem_r_valid_i <= 1'b1;
          mem_resp_idx++;
        end
      end
      if (r_valid_o && r_ready_i) begin
        check_resp($sformatf("read %0d response", resp_cnt), golden_resp(resp_cnt), r_o);
        if (golden_words[resp_cnt*WORDS+4][0]) begin
          exp_cm_q.push_back(golden_words[resp_cnt*WORDS+5][CM_ADDR_W-1:0]);
          snoop_resp_cnt++;
          ack_pending++;
        end
        resp_cnt++;
      end
      r_ready_i <= random_bit();
      if (cm_req_o) begin
        if (exp_cm_q.size() == 0) begin
          abort_run("Conflict-monitor request with no snooping read waiting");
        end else begin
          check_cm_addr($sformatf("ack %0d line index", cm_cnt), exp_cm_q.pop_front(),
                        cm_addr_o);
          cm_cnt++;
        end
      end
      if (snoop_resp_cnt - cm_cnt > int'(ACK_DEPTH)) begin
        abort_run("More than two snooping responses delivered ahead of their acknowledges");
      end
      rack_i <= 1'b0;
      if (!rack_hold && ack_pending > 0 && random_bit()) begin
        rack_i <= 1'b1;
        ack_pending--;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    repeat (RESET_CYCLES + NUM_READS * CYCLES_PER_READ) @(posedge clk);
    abort_run("Timeout: the reads did not complete in the allowed time");
  end

  initial begin
    $readmemh("tests/ccu_read_path_golden.txt", golden_words);
    for (int k = 0; k < NUM_READS; k++) begin
      if (golden_words[k*WORDS+4][0]) begin
        num_snoop++;
      end
    end
    @(negedge reset);
    repeat (8) begin
      @(negedge clk);
      check_bit("idle r_valid_o", 1'b0, r_valid_o);
      check_bit("idle cm_req_o", 1'b0, cm_req_o);
      check_bit("idle mem_ar_valid_o", 1'b0, mem_ar_valid_o);
      check_bit("idle ar_ready_o", 1'b1, ar_ready_o);
    end
    // Memory silent, so the tag queue fills
    traffic_on = 1'b1;
    wait (mem_acc_cnt == int'(TAG_DEPTH));
    repeat (10) begin
      @(negedge clk);
      check_bit("stalled ar_ready_o", 1'b0, ar_ready_o);
    end
    if (mem_acc_cnt != int'(TAG_DEPTH) || resp_cnt != 0) begin
      abort_run("Reads accepted past the tag queue depth or answered during the stall");
    end
    // Acknowledges still withheld
    mem_r_hold = 1'b0;
    wait (snoop_resp_cnt == 2);
    repeat (40) @(negedge clk);
    if (snoop_resp_cnt != 2 || !mem_r_valid_i || r_valid_o) begin
      abort_run("Third snooping response was not held back by the full ack queue");
    end
    rack_hold = 1'b0;
    wait (resp_cnt == NUM_READS && cm_cnt == num_snoop);
    repeat (4) @(negedge clk);
    if (!r_valid_o && !mem_ar_valid_o && !cm_req_o) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort_run("DUT still active after the last read completed");
    end
  end

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int unsigned HALF_PERIOD_NS = 4,
  parameter int unsigned RESET_CYCLES   = 16
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Released on a rising edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule
